//--- compile.f
logic/sms_mem_pkg.sv
logic/sms_cheat_pkg.sv
logic/cart_loader.sv
logic/cheat_loader.sv
logic/rom_port.sv
logic/sms_cart_top.sv
testbench/cart_bus_props.sv
testbench/cart_checker.sv
testbench/tb_sms_cart.sv

//--- Makefile
# Verilator build and run of the cartridge subsystem testbench
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_sms_cart
FILELIST  := compile.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and scan the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF "*** TEST FAILED ***" $(LOG) || \
		! grep -qF "*** TEST PASSED ***" $(LOG); then \
		echo "Simulation did not pass, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- testbench/tb_sms_cart.sv
/*
 * Testbench top for the cartridge subsystem
 *   Clock, reset, download and read stimulus
 *   Wishbone slave memory with random ack delay
 *   Reference model of the address map and cheat patching
 */
`timescale 1ns/1ps
`default_nettype none

module tb_sms_cart;

	import sms_mem_pkg::*;
	import sms_cheat_pkg::*;

	localparam int TIMEOUT = 200;  // Cycles allowed per wait

	logic         clk_sys;
	logic         rst_n;
	dl_beat_t     dl;
	logic         dl_wait;
	logic         cheat_en;
	rom_req_t     rd_req;
	rom_rsp_t     rd_rsp;
	wb_req_t      wb_m;
	wb_rsp_t      wb_s = '0;
	logic         cheat_avail;
	logic         loading;
	byte_t        exp_rd;
	int           n_checks;
	int           n_errors;

	byte_t        mem [0:2047];  // Slave memory
	byte_t        img [0:2047];  // Reference image
	int           ack_delay = -1;
	rom_addr_t    exp_mask;
	rom_addr_t    exp_mask_hdr;
	logic         exp_hdr;
	cheat_entry_t cheats[$];

	sms_cart_top dut (.*);

	cart_checker u_checker (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.dl      (dl),
		.dl_wait (dl_wait),
		.rd_req  (rd_req),
		.rd_rsp  (rd_rsp),
		.wb_m    (wb_m),
		.wb_s    (wb_s),
		.exp_rd  (exp_rd),
		.checks  (n_checks),
		.errors  (n_errors)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// ========================================
	// Wishbone slave, 0 to 3 wait cycles
	// ========================================
	always @(negedge clk_sys) begin
		if (!rst_n || wb_s.ack) begin
			wb_s.ack  = 1'b0;  // One-cycle ack
			ack_delay = -1;
		end else if (wb_m.cyc && wb_m.stb) begin
			if (ack_delay < 0) ack_delay = int'($urandom_range(0, 3));
			if (ack_delay == 0) begin
				wb_s.ack = 1'b1;
				if (wb_m.we) mem[wb_m.adr[10:0]] = wb_m.dat_w;
				else wb_s.dat_r = mem[wb_m.adr[10:0]];
			end else begin
				ack_delay--;
			end
		end
	end

	// Header skip or plain mask, then the first matching cheat
	function automatic byte_t expected_read(input rom_addr_t a);
		rom_addr_t m;
		byte_t     d;
		logic      hit;
		if (exp_hdr) m = (a + rom_addr_t'(HDR_BYTES)) & exp_mask_hdr;
		else m = a & exp_mask;
		d   = img[m[10:0]];
		hit = 1'b0;
		foreach (cheats[i]) begin
			if (!hit && cheats[i].addr == {10'd0, a}) begin
				hit = 1'b1;
				if (cheat_en && (!cheats[i].flags[FLAG_COMPARE] || d == cheats[i].compare[7:0]))
					d = cheats[i].replace[7:0];
			end
		end
		return d;
	endfunction

	task automatic abort_on_timeout(input string what);
		$display("Timeout: %s at %0t", what, $time);
		$display("*** TEST FAILED ***");
		$finish;
	endtask

	task automatic send_beat(input dl_addr_t addr, input byte_t data);
		int n;
		@(negedge clk_sys);
		dl.wr   = 1'b1;
		dl.addr = addr;
		dl.data = data;
		@(negedge clk_sys);
		dl.wr = 1'b0;
		n = 0;
		while (dl_wait) begin
			@(negedge clk_sys);
			if (++n > TIMEOUT) abort_on_timeout("dl_wait stayed high");
		end
	endtask

	// ========================================
	// Stimulus tasks
	// ========================================
	task automatic load_image(input int size);
		int n;
		exp_mask     = '0;
		exp_mask_hdr = '0;
		for (int i = 0; i < size; i++) img[i] = byte_t'($urandom);
		for (int i = 1; i < size; i++) exp_mask |= rom_addr_t'(i);
		for (int i = HDR_BYTES + 1; i < size; i++) exp_mask_hdr |= rom_addr_t'(i - HDR_BYTES);
		exp_hdr = (size & HDR_BYTES) != 0;
		cheats.delete();  // Offset 0 clears the table
		@(negedge clk_sys);
		dl.index    = 8'h00;
		dl.download = 1'b1;
		for (int i = 0; i < size; i++) send_beat(dl_addr_t'(i), img[i]);
		@(negedge clk_sys);
		dl.download = 1'b0;
		n = 0;
		while (loading) begin
			@(negedge clk_sys);
			if (++n > TIMEOUT) abort_on_timeout("loading stayed high after download");
		end
	endtask

	task automatic load_cheat(input cheat_word_t c_flags, input cheat_word_t c_addr,
		input cheat_word_t c_cmp, input cheat_word_t c_rep);
		cheat_word_t  f [4];
		cheat_entry_t e;
		int           n;
		f = '{c_flags, c_addr, c_cmp, c_rep};
		@(negedge clk_sys);
		dl.index    = CODE_INDEX;
		dl.download = 1'b1;
		for (int k = 0; k < CODE_BYTES; k++) send_beat(dl_addr_t'(k), f[k / 4][8 * (k % 4) +: 8]);
		dl.download = 1'b0;
		e = '{valid: 1'b1, flags: c_flags, addr: c_addr, compare: c_cmp, replace: c_rep};
		if (cheats.size() < CHEAT_SLOTS) cheats.push_back(e);
		n = 0;
		while (!cheat_avail) begin
			@(negedge clk_sys);
			if (++n > TIMEOUT) abort_on_timeout("cheat_avail did not rise");
		end
	endtask

	task automatic read_check(input rom_addr_t addr);
		int n;
		@(negedge clk_sys);
		rd_req = '{valid: 1'b1, addr: addr};
		exp_rd = expected_read(addr);  // Held until the next read
		n = 0;
		@(negedge clk_sys);
		while (!rd_rsp.ready) begin
			@(negedge clk_sys);
			if (++n > TIMEOUT) abort_on_timeout("no read response");
		end
		rd_req.valid = 1'b0;
	endtask

	// ========================================
	// Test sequence
	// ========================================
	initial begin
		byte_t f;
		void'($urandom(44));
		rst_n    = 1'b0;
		dl       = '0;
		cheat_en = 1'b0;
		rd_req   = '0;
		exp_rd   = '0;
		repeat (10) @(negedge clk_sys);
		rst_n = 1'b1;

		load_image(1024);
		read_check(22'h3fffff);
		for (int i = 0; i < 24; i++) read_check(rom_addr_t'($urandom_range(0, 8191)));

		load_image(1536);  // Carries a header
		for (int i = 0; i < 24; i++) read_check(rom_addr_t'($urandom_range(0, 4095)));

		f = expected_read(22'h0123);
		load_cheat(32'h0, 32'h0123, 32'h0, {24'h0, ~f});
		cheat_en = 1'b1;
		read_check(22'h0123);
		cheat_en = 1'b0;
		read_check(22'h0123);

		cheat_en = 1'b1;
		f = expected_read(22'h0200);
		load_cheat(32'h1, 32'h0200, {24'h0, f}, {24'h0, ~f});  // Compare matches
		f = expected_read(22'h0345);
		load_cheat(32'h1, 32'h0345, {24'h0, f ^ 8'h01}, {24'h0, ~f});
		read_check(22'h0200);
		read_check(22'h0345);
		read_check(22'h0123);

		load_image(1024);
		for (int n = 0; cheat_avail; n++) begin
			@(negedge clk_sys);
			if (n > TIMEOUT) abort_on_timeout("cheat_avail stayed high after new download");
		end
		read_check(22'h0123);
		read_check(22'h0200);

		repeat (4) @(negedge clk_sys);
		$display("Checks: %0d, errors: %0d, assertion errors: %0d", n_checks, n_errors,
			dut.u_rom_port.u_bus_props.viol_cnt);
		if (n_errors == 0 && dut.u_rom_port.u_bus_props.viol_cnt == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/cart_checker.sv
/*
 * Result checker
 *   Cart writes against the download bytes, in order from address 0
 *   dl_wait release after each write ack
 *   Read responses against the expected byte from the testbench
 */
`timescale 1ns/1ps
`default_nettype none

module cart_checker (
	input  wire                         clk_sys,
	input  wire                         rst_n,
	input  wire sms_mem_pkg::dl_beat_t  dl,
	input  wire                         dl_wait,
	input  wire sms_mem_pkg::rom_req_t  rd_req,
	input  wire sms_mem_pkg::rom_rsp_t  rd_rsp,
	input  wire sms_mem_pkg::wb_req_t   wb_m,
	input  wire sms_mem_pkg::wb_rsp_t   wb_s,
	input  wire sms_mem_pkg::byte_t     exp_rd,
	output int                          checks,
	output int                          errors
);

	import sms_mem_pkg::*;

	byte_t     beats[$];  // Cart bytes taken but not yet written
	rom_addr_t wr_idx;
	logic      cart_q;
	logic      wr_ack_q;
	logic      cart_dl;

	assign cart_dl = dl.download && (dl.index != CODE_INDEX);

	function automatic void report_mismatch(input string msg);
		errors++;
		$display("FAIL %0t: %s", $time, msg);
	endfunction

	// Sampled on the rising edge, inputs move on the falling one
	always @(posedge clk_sys) begin
		byte_t exp_b;
		if (!rst_n) begin
			checks   = 0;
			errors   = 0;
			wr_idx   = '0;
			cart_q   = 1'b0;
			wr_ack_q = 1'b0;
			beats.delete();
		end else begin
			if (cart_dl && !cart_q) begin
				beats.delete();  // New image
				wr_idx = '0;
			end
			if (wr_ack_q && dl_wait) begin
				report_mismatch("dl_wait still high one cycle after write ack");
			end
			if (wb_m.cyc && wb_m.stb && wb_m.we && wb_s.ack) begin
				checks++;
				if (beats.size() == 0) begin
					report_mismatch($sformatf("write to %h with no byte pending", wb_m.adr));
				end else begin
					exp_b = beats.pop_front();
					if (wb_m.adr != wr_idx || wb_m.dat_w != exp_b) begin
						report_mismatch($sformatf("write %h=%h, expected %h=%h",
							wb_m.adr, wb_m.dat_w, wr_idx, exp_b));
					end
				end
				wr_idx++;
			end
			if (cart_dl && dl.wr) beats.push_back(dl.data);
			if (rd_rsp.ready) begin
				checks++;
				// Reads only follow a finished download
				if (beats.size() != 0) begin
					report_mismatch($sformatf("%0d cart bytes never written", beats.size()));
					beats.delete();
				end
				if (rd_rsp.data !== exp_rd) begin
					report_mismatch($sformatf("read at %h gave %h, expected %h",
						rd_req.addr, rd_rsp.data, exp_rd));
				end
			end
			wr_ack_q = wb_m.we && wb_s.ack;
			cart_q   = cart_dl;
		end
	end

endmodule

`default_nettype wire

//--- testbench/cart_bus_props.sv
/*
 * Wishbone and read-port assertions
 *   Request steady until ack, cycle ends the cycle after ack
 *   Read response only after a read ack, never during a download
 */
`timescale 1ns/1ps
`default_nettype none

module cart_bus_props (
	input wire                         clk_sys,
	input wire                         rst_n,
	input wire                         loading,
	input wire sms_mem_pkg::wb_req_t   wb_m,
	input wire sms_mem_pkg::wb_rsp_t   wb_s,
	input wire sms_mem_pkg::rom_rsp_t  rd_rsp
);

	int unsigned viol_cnt = 0;  // Read by the testbench top at the end

	// Both strobes drop the cycle after ack, one transfer per cycle pair
	a_cycle_end: assert property (@(posedge clk_sys) disable iff (!rst_n)
		wb_m.stb && wb_s.ack |=> !wb_m.cyc && !wb_m.stb)
		else begin $error("cyc or stb still high after ack"); viol_cnt++; end

	// Classic cycle, master waits for the slave
	a_req_steady: assert property (@(posedge clk_sys) disable iff (!rst_n)
		wb_m.stb && !wb_s.ack |=> wb_m.cyc && wb_m.stb && $stable(wb_m.adr) &&
			$stable(wb_m.we) && $stable(wb_m.dat_w))
		else begin $error("request changed before ack"); viol_cnt++; end

	a_rsp_after_read: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rd_rsp.ready |-> !loading && $past(wb_m.cyc && !wb_m.we && wb_s.ack))
		else begin $error("read response without a read ack or during download"); viol_cnt++; end

endmodule

bind rom_port cart_bus_props u_bus_props (
	.clk_sys (clk_sys),
	.rst_n   (rst_n),
	.loading (loading),
	.wb_m    (wb_m),
	.wb_s    (wb_s),
	.rd_rsp  (rd_rsp)
);

`default_nettype wire

//--- logic/sms_cart_top.sv
/*
 * Cartridge subsystem top
 *   Cart loader, cheat loader and ROM port
 */
`timescale 1ns/1ps
`default_nettype none

module sms_cart_top (
	input  wire                         clk_sys,
	input  wire                         rst_n,
	input  wire sms_mem_pkg::dl_beat_t  dl,
	output wire                         dl_wait,
	input  wire                         cheat_en,
	input  wire sms_mem_pkg::rom_req_t  rd_req,
	output wire sms_mem_pkg::rom_rsp_t  rd_rsp,
	output wire sms_mem_pkg::wb_req_t   wb_m,
	input  wire sms_mem_pkg::wb_rsp_t   wb_s,
	output wire                         cheat_avail,
	output wire                         loading
);

	import sms_mem_pkg::*;
	import sms_cheat_pkg::*;

	cart_map_t    cart_map;
	wb_req_t      wb_wr;     // Loader write request
	logic         wb_wr_ack;
	cheat_table_t cheat_table;

	cart_loader u_cart_loader (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.dl       (dl),
		.dl_wait  (dl_wait),
		.wb_wr    (wb_wr),
		.wb_ack   (wb_wr_ack),
		.loading  (loading),
		.cart_map (cart_map)
	);

	cheat_loader u_cheat_loader (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.dl          (dl),
		.cheat_table (cheat_table),
		.cheat_avail (cheat_avail)
	);

	// Only bus master towards the memory
	rom_port u_rom_port (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.loading     (loading),
		.wb_wr       (wb_wr),
		.wb_wr_ack   (wb_wr_ack),
		.cart_map    (cart_map),
		.cheat_table (cheat_table),
		.cheat_en    (cheat_en),
		.rd_req      (rd_req),
		.rd_rsp      (rd_rsp),
		.wb_m        (wb_m),
		.wb_s        (wb_s)
	);

endmodule

`default_nettype wire

//--- logic/rom_port.sv
/*
 * ROM port
 *   Bus sharing between the cart loader and console reads
 *   Read FSM with header skip and image masking
 *   Cheat match and byte patch on the read data
 */
`timescale 1ns/1ps
`default_nettype none

module rom_port (
	input  wire                               clk_sys,
	input  wire                               rst_n,
	input  wire                               loading,
	input  wire sms_mem_pkg::wb_req_t         wb_wr,
	output logic                              wb_wr_ack,
	input  wire sms_mem_pkg::cart_map_t       cart_map,
	input  wire sms_cheat_pkg::cheat_table_t  cheat_table,
	input  wire                               cheat_en,
	input  wire sms_mem_pkg::rom_req_t        rd_req,
	output sms_mem_pkg::rom_rsp_t             rd_rsp,
	output sms_mem_pkg::wb_req_t              wb_m,
	input  wire sms_mem_pkg::wb_rsp_t         wb_s
);

	import sms_mem_pkg::*;
	import sms_cheat_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_RESP
	} rd_state_t;

	rd_state_t state;
	rom_addr_t req_addr;  // Console address, used for the cheat match
	rom_addr_t bus_addr;  // Mapped address driven on the bus
	rom_addr_t map_addr;
	byte_t     rd_data;
	byte_t     patched;
	logic      hit;
	logic      rd_ack;
	wb_req_t   rd_bus;

	// ========================================
	// Address map
	// ========================================
	always_comb begin
		if (cart_map.has_hdr) begin
			map_addr = (rd_req.addr + rom_addr_t'(HDR_BYTES)) & cart_map.mask_hdr;
		end else begin
			map_addr = rd_req.addr & cart_map.mask;
		end
	end

	// ========================================
	// Read FSM
	// ========================================
	assign rd_ack = (state == ST_READ) && !loading && wb_s.ack;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: if (rd_req.valid && !loading) state <= ST_READ;
				ST_READ: begin
					if (loading) begin
						state <= ST_IDLE;  // Loader takes the bus, read is retried
					end else if (rd_ack) begin
						state <= ST_RESP;
					end
				end
				ST_RESP: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (state == ST_IDLE && rd_req.valid) begin
			req_addr <= rd_req.addr;
			bus_addr <= map_addr;
		end
		if (rd_ack) begin
			rd_data <= patched;
		end
	end

	// Lowest matching slot decides, even when its compare fails
	always_comb begin
		patched = wb_s.dat_r;
		hit     = 1'b0;
		for (int i = 0; i < CHEAT_SLOTS; i++) begin
			if (!hit && cheat_table[i].valid &&
				cheat_table[i].addr == cheat_word_t'(req_addr)) begin
				hit = 1'b1;
				if (cheat_en && (!cheat_table[i].flags[FLAG_COMPARE] ||
					wb_s.dat_r == cheat_table[i].compare[7:0])) begin
					patched = cheat_table[i].replace[7:0];
				end
			end
		end
	end

	// ========================================
	// Bus sharing
	// ========================================
	assign rd_bus = '{cyc: (state == ST_READ), stb: (state == ST_READ), we: 1'b0,
		adr: bus_addr, dat_w: '0};

	assign wb_m      = loading ? wb_wr : rd_bus;
	assign wb_wr_ack = loading && wb_s.ack;
	assign rd_rsp    = '{ready: (state == ST_RESP) && !loading, data: rd_data};

endmodule

`default_nettype wire

//--- logic/cheat_loader.sv
/*
 * Cheat code loader
 *   Byte assembly of 16-byte codes from the cheat stream
 *   Table of CHEAT_SLOTS entries filled in order
 *   Table clear at the start of a cart image
 */
`timescale 1ns/1ps
`default_nettype none

module cheat_loader (
	input  wire                          clk_sys,
	input  wire                          rst_n,
	input  wire sms_mem_pkg::dl_beat_t   dl,
	output sms_cheat_pkg::cheat_table_t  cheat_table,
	output logic                         cheat_avail
);

	import sms_mem_pkg::*;
	import sms_cheat_pkg::*;

	logic         code_wr;
	logic         tbl_clr;
	logic         code_last;
	logic         tbl_full;
	code_off_t    code_off;
	cheat_word_t  flags_q;
	cheat_word_t  addr_q;
	cheat_word_t  cmp_q;
	cheat_word_t  rep_q;
	cheat_entry_t new_entry;
	cheat_table_t table_q;
	slot_cnt_t    fill_cnt;

	assign code_wr   = dl.download && dl.wr && (dl.index == CODE_INDEX);
	assign tbl_clr   = dl.download && dl.wr && (dl.index != CODE_INDEX) && (dl.addr == '0);
	assign code_off  = dl.addr[OFF_W-1:0];
	assign code_last = code_wr && (code_off == code_off_t'(CODE_BYTES - 1));
	assign tbl_full  = (fill_cnt == slot_cnt_t'(CHEAT_SLOTS));

	// Fields are little-endian, two offset bits pick the field
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (code_off[3:2])
				2'd0: flags_q[{code_off[1:0], 3'b000} +: 8] <= dl.data;
				2'd1: addr_q[{code_off[1:0], 3'b000} +: 8]  <= dl.data;
				2'd2: cmp_q[{code_off[1:0], 3'b000} +: 8]   <= dl.data;
				default: rep_q[{code_off[1:0], 3'b000} +: 8] <= dl.data;
			endcase
		end
	end

	always_comb begin
		new_entry = '{valid: 1'b1, flags: flags_q, addr: addr_q, compare: cmp_q, replace: rep_q};
		new_entry.replace[31:24] = dl.data;  // Top byte comes with the commit beat
	end

	// ========================================
	// Table fill
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			table_q  <= '0;
			fill_cnt <= '0;
		end else if (tbl_clr) begin
			table_q  <= '0;
			fill_cnt <= '0;
		end else if (code_last && !tbl_full) begin
			table_q[fill_cnt[SLOT_W-1:0]] <= new_entry;
			fill_cnt <= fill_cnt + 1'b1;
		end
	end

	assign cheat_table = table_q;
	assign cheat_avail = (fill_cnt != '0);

endmodule

`default_nettype wire

//--- logic/cart_loader.sv
/*
 * Cart download to Wishbone write converter
 *   One bus write per download byte, with dl_wait back-pressure
 *   Address mask, header mask and header flag of the loaded image
 */
`timescale 1ns/1ps
`default_nettype none

module cart_loader (
	input  wire                         clk_sys,
	input  wire                         rst_n,
	input  wire sms_mem_pkg::dl_beat_t  dl,
	output logic                        dl_wait,
	output sms_mem_pkg::wb_req_t        wb_wr,
	input  wire                         wb_ack,
	output logic                        loading,
	output sms_mem_pkg::cart_map_t      cart_map
);

	import sms_mem_pkg::*;

	logic      cart_dl;
	logic      cart_wr;
	logic      dl_prev;
	logic      dl_rise;
	logic      dl_fall;
	logic      wr_busy;   // Write request outstanding on the bus
	rom_addr_t wr_addr;   // Next address to write
	rom_addr_t wr_adr;
	byte_t     wr_dat;
	dl_addr_t  img_size;
	cart_map_t map_q;

	assign cart_dl = dl.download && (dl.index != CODE_INDEX);
	assign cart_wr = cart_dl && dl.wr;
	assign dl_rise = cart_dl && !dl_prev;
	assign dl_fall = !cart_dl && dl_prev;

	// ========================================
	// Write request and handshake
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			dl_prev <= 1'b0;
			wr_busy <= 1'b0;
			wr_addr <= '0;
		end else begin
			dl_prev <= cart_dl;
			if (dl_rise) begin
				wr_addr <= '0;  // New image starts at zero
			end
			if (cart_wr) begin
				wr_busy <= 1'b1;
			end else if (wr_busy && wb_ack) begin
				wr_busy <= 1'b0;
				wr_addr <= wr_adr + 1'b1;
			end
		end
	end

	// Held steady until ack
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			wr_adr <= dl_rise ? '0 : wr_addr;  // First beat may come with the edge
			wr_dat <= dl.data;
		end
	end

	// ========================================
	// Address map of the image
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			map_q <= '0;
		end else begin
			if (cart_wr) begin
				if (dl.addr == '0) begin
					map_q.mask <= '0;
				end else begin
					map_q.mask <= map_q.mask | dl.addr[21:0];
				end
				// Offsets below the header wrap high and are wiped at HDR_BYTES
				if (dl.addr == dl_addr_t'(HDR_BYTES)) begin
					map_q.mask_hdr <= '0;
				end else begin
					map_q.mask_hdr <= map_q.mask_hdr | (dl.addr[21:0] - rom_addr_t'(HDR_BYTES));
				end
			end
			if (dl_rise) begin
				map_q.has_hdr <= 1'b0;
			end else if (dl_fall) begin
				map_q.has_hdr <= img_size[$clog2(HDR_BYTES)];  // Size is 512 past a bank
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			img_size <= dl.addr + 1'b1;
		end
	end

	assign dl_wait  = wr_busy;
	assign loading  = dl_prev || wr_busy;  // Covers the last write after download drops
	assign cart_map = map_q;
	assign wb_wr    = '{cyc: wr_busy, stb: wr_busy, we: 1'b1, adr: wr_adr, dat_w: wr_dat};

endmodule

`default_nettype wire

//--- logic/sms_cheat_pkg.sv
/*
 * Cheat code definitions
 *   Field and entry layout of one code
 *   Table size, slot counter and byte offset types
 *   Flag bit positions
 */
`default_nettype none

package sms_cheat_pkg;

	// ========================================
	// Sizes
	// ========================================
	localparam int CHEAT_SLOTS = 4;
	localparam int CODE_BYTES  = 16;  // flags, addr, compare, replace
	localparam int SLOT_W      = $clog2(CHEAT_SLOTS);
	localparam int OFF_W       = $clog2(CODE_BYTES);

	localparam int FLAG_COMPARE = 0;  // Patch only on a matching fetched byte

	typedef logic [31:0]      cheat_word_t;
	typedef logic [SLOT_W:0]  slot_cnt_t;  // Counts 0 to CHEAT_SLOTS
	typedef logic [OFF_W-1:0] code_off_t;

	// ========================================
	// Table layout
	// ========================================
	typedef struct packed {
		logic        valid;
		cheat_word_t flags;
		cheat_word_t addr;
		cheat_word_t compare;
		cheat_word_t replace;
	} cheat_entry_t;

	// Slot 0 has the highest priority on a read
	typedef cheat_entry_t [CHEAT_SLOTS-1:0] cheat_table_t;

endpackage

`default_nettype wire

//--- logic/sms_mem_pkg.sv
/*
 * Memory-side definitions for the cartridge path
 *   Scalar types for bytes, ROM addresses and download offsets
 *   Download beat and cartridge address map
 *   Console read request and response
 *   Wishbone classic request and response
 */
`default_nettype none

package sms_mem_pkg;

	// ========================================
	// Scalar types and constants
	// ========================================
	typedef logic [7:0]  byte_t;
	typedef logic [21:0] rom_addr_t;  // 4 MB console ROM space
	typedef logic [24:0] dl_addr_t;
	typedef logic [7:0]  dl_index_t;

	localparam dl_index_t   CODE_INDEX = 8'hff;  // Stream index of cheat codes
	localparam int unsigned HDR_BYTES  = 512;    // Copier header in front of the image

	// ========================================
	// Structured signals
	// ========================================
	typedef struct packed {
		logic      wr;        // One-cycle pulse per byte
		logic      download;
		dl_index_t index;
		dl_addr_t  addr;
		byte_t     data;
	} dl_beat_t;

	typedef struct packed {
		rom_addr_t mask;
		rom_addr_t mask_hdr;  // Mask of the image with the header skipped
		logic      has_hdr;
	} cart_map_t;

	typedef struct packed {
		logic      valid;
		rom_addr_t addr;
	} rom_req_t;

	typedef struct packed {
		logic  ready;
		byte_t data;
	} rom_rsp_t;

	typedef struct packed {
		logic      cyc;
		logic      stb;
		logic      we;
		rom_addr_t adr;
		byte_t     dat_w;
	} wb_req_t;

	typedef struct packed {
		logic  ack;
		byte_t dat_r;
	} wb_rsp_t;

endpackage

`default_nettype wire
